//--- build.f
rtl/harness_pkg.sv
rtl/periph_decode.sv
rtl/power_ctrl_regs.sv
rtl/switch_ack_model.sv
rtl/exit_regs.sv
rtl/obi_buffer.sv
rtl/slow_memory.sv
rtl/ext_harness_top.sv
testbench/ext_harness_assertions.sv
testbench/tb_ext_harness.sv

//--- Bender.yml
package:
  name: ext_harness

sources:
  - files:
      - rtl/harness_pkg.sv
      - rtl/periph_decode.sv
      - rtl/power_ctrl_regs.sv
      - rtl/switch_ack_model.sv
      - rtl/exit_regs.sv
      - rtl/obi_buffer.sv
      - rtl/slow_memory.sv
      - rtl/ext_harness_top.sv
  - target: test
    files:
      - testbench/ext_harness_assertions.sv
      - testbench/tb_ext_harness.sv

//--- testbench/tb_ext_harness.sv
// Directed testbench for the external harness: register decode,
// power switch latency, done interrupt, slow memory and exit register
module tb_ext_harness
  import harness_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NUM_DOMAINS        = 4;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned MEM_WORDS          = 1024;
  localparam int          CLK_PERIOD         = 40;
  localparam int          TIMEOUT_CYCLES     = 2000;
  localparam int          MEM_TESTS          = 12;

  typedef logic [NUM_DOMAINS-1:0] domains_t;

  logic     clk;
  logic     rst_n;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  obi_req_t obi_req;
  obi_rsp_t obi_rsp;
  domains_t switch_n;
  domains_t ack_n;
  logic     intr;
  logic     exit_valid;
  data_t    exit_value;
  domains_t prev_pattern = '0;
  int       errors = 0;
  int       cycles = 0;
  int       seed   = 51153;

  ext_harness_top #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY),
    .MEM_WORDS         (MEM_WORDS)
  ) uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .reg_req_i   (reg_req),
    .reg_rsp_o   (reg_rsp),
    .obi_req_i   (obi_req),
    .obi_rsp_o   (obi_rsp),
    .switch_n_o  (switch_n),
    .ack_n_o     (ack_n),
    .intr_o      (intr),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_domains(input string name, input domains_t exp, input domains_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_rsp_error(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected error %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // One register bus access, completed in the cycle it is presented
  task automatic reg_access(input string name, input addr_t addr, input logic write,
                            input data_t wdata, output reg_rsp_t rsp);
    @(negedge clk);
    reg_req.addr  = addr;
    reg_req.write = write;
    reg_req.wdata = wdata;
    reg_req.wstrb = 4'hF;
    reg_req.valid = 1'b1;
    #(CLK_PERIOD / 4);
    rsp = reg_rsp;
    check_bit({name, " ready"}, 1'b1, rsp.ready);
    @(negedge clk);
    reg_req.valid = 1'b0;
  endtask

  task automatic reg_write(input string name, input addr_t addr, input data_t wdata);
    reg_rsp_t rsp;
    reg_access(name, addr, 1'b1, wdata, rsp);
    check_rsp_error(name, 1'b0, rsp.error);
  endtask

  task automatic reg_read(input string name, input addr_t addr, output data_t rdata);
    reg_rsp_t rsp;
    reg_access(name, addr, 1'b0, '0, rsp);
    check_rsp_error(name, 1'b0, rsp.error);
    rdata = rsp.rdata;
  endtask

  // Holds req until granted, then times the response
  task automatic obi_access(input string name, input logic we, input strb_t be,
                            input addr_t addr, input data_t wdata, output data_t rdata);
    int waits;
    int lat;
    @(negedge clk);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    #(CLK_PERIOD / 4);
    waits = 0;
    while (!obi_rsp.gnt && waits < 8) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      waits++;
    end
    if (!obi_rsp.gnt) begin
      errors++;
      $display("%s: the OBI request was never granted", name);
    end
    lat = 0;
    do begin
      @(negedge clk);
      obi_req.req = 1'b0;
      #(CLK_PERIOD / 4);
      lat++;
    end while (!obi_rsp.rvalid && lat < 8);
    check_data({name, " latency"}, 32'd2, data_t'(lat));
    rdata = obi_rsp.rdata;
  endtask

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic test_reset_state();
    data_t rd;
    reg_read("reset switch", POWER_BASE + REG_SWITCH, rd);
    check_data("reset switch", '0, rd);
    reg_read("reset irq", POWER_BASE + REG_IRQ, rd);
    check_data("reset irq", '0, rd);
    reg_read("reset exit", EXIT_BASE + REG_EXIT_VALUE, rd);
    check_data("reset exit", '0, rd);
    check_bit("reset intr", 1'b0, intr);
    check_bit("reset exit valid", 1'b0, exit_valid);
    check_data("reset exit value", '0, exit_value);
    check_domains("reset switch_n", '0, switch_n);
    check_domains("reset ack_n", '0, ack_n);
    check_bit("reset obi rvalid", 1'b0, obi_rsp.rvalid);
  endtask

  // Writes a new pattern and follows the acknowledge through the delay
  task automatic switch_transition(input string name, input domains_t pattern,
                                   input bit expect_intr);
    domains_t old_ack;
    data_t    rd;
    old_ack = prev_pattern;
    reg_write({name, " write"}, POWER_BASE + REG_SWITCH, data_t'(pattern));
    check_domains({name, " switch_n"}, pattern, switch_n);
    for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
      check_domains({name, " ack hold"}, old_ack, ack_n);
      @(negedge clk);
    end
    check_domains({name, " ack"}, pattern, ack_n);
    check_bit({name, " intr before done"}, 1'b0, intr);
    @(negedge clk);
    check_bit({name, " intr"}, expect_intr, intr);
    reg_read({name, " ack status"}, POWER_BASE + REG_ACK_STATUS, rd);
    check_data({name, " ack status"}, data_t'(pattern), rd);
    prev_pattern = pattern;
  endtask

  task automatic test_done_interrupt();
    data_t rd;
    reg_write("irq clear", POWER_BASE + REG_IRQ, 32'h1);
    reg_write("irq enable", POWER_BASE + REG_IRQ_EN, 32'h1);
    switch_transition("irq enabled", 4'b1010, 1'b1);
    reg_read("irq done", POWER_BASE + REG_IRQ, rd);
    check_data("irq done", 32'h1, rd);
    reg_write("irq clear", POWER_BASE + REG_IRQ, 32'h1);
    check_bit("intr after clear", 1'b0, intr);
    reg_read("irq cleared", POWER_BASE + REG_IRQ, rd);
    check_data("irq cleared", '0, rd);
    reg_write("irq disable", POWER_BASE + REG_IRQ_EN, '0);
    switch_transition("irq masked", 4'b0011, 1'b0);
    reg_read("irq masked done", POWER_BASE + REG_IRQ, rd);
    check_data("irq masked done", 32'h1, rd);
    check_bit("intr masked", 1'b0, intr);
  endtask

  task automatic test_decode_error();
    reg_rsp_t rsp;
    data_t    rd;
    reg_access("decode low write", 32'h1000_0000, 1'b1, 32'hF, rsp);
    check_rsp_error("decode low write", 1'b1, rsp.error);
    check_data("decode low write rdata", '0, rsp.rdata);
    reg_access("decode high write", EXIT_BASE + SLOT_SPAN, 1'b1, 32'h55, rsp);
    check_rsp_error("decode high write", 1'b1, rsp.error);
    reg_access("decode read", 32'h0000_0008, 1'b0, '0, rsp);
    check_rsp_error("decode read", 1'b1, rsp.error);
    check_data("decode read rdata", '0, rsp.rdata);
    reg_read("decode switch after", POWER_BASE + REG_SWITCH, rd);
    check_data("decode switch after", data_t'(prev_pattern), rd);
    check_bit("decode exit valid", 1'b0, exit_valid);
  endtask

  task automatic test_memory();
    addr_t addrs    [MEM_TESTS];
    data_t expected [MEM_TESTS];
    data_t wd;
    data_t rd;
    strb_t be;
    // Disjoint 64-word windows keep the addresses distinct
    for (int i = 0; i < MEM_TESTS; i++) begin
      addrs[i] = addr_t'((i * 64 + ($random(seed) & 63)) * 4);
      wd = $random(seed);
      obi_access($sformatf("mem fill %0d", i), 1'b1, 4'hF, addrs[i], wd, rd);
      check_data($sformatf("mem fill %0d rdata", i), '0, rd);
      expected[i] = wd;
    end
    for (int i = 0; i < MEM_TESTS; i++) begin
      wd = $random(seed);
      be = strb_t'($random(seed));
      obi_access($sformatf("mem merge %0d", i), 1'b1, be, addrs[i], wd, rd);
      check_data($sformatf("mem merge %0d rdata", i), '0, rd);
      expected[i] = merge_bytes(expected[i], wd, be);
    end
    for (int i = 0; i < MEM_TESTS; i++) begin
      obi_access($sformatf("mem read %0d", i), 1'b0, 4'hF, addrs[i], '0, rd);
      check_data($sformatf("mem read %0d", i), expected[i], rd);
    end
  endtask

  task automatic test_exit_register();
    data_t rd;
    reg_write("exit first", EXIT_BASE + REG_EXIT_VALUE, 32'hCAFE_0051);
    check_bit("exit first valid", 1'b1, exit_valid);
    check_data("exit first value", 32'hCAFE_0051, exit_value);
    reg_read("exit readback", EXIT_BASE + REG_EXIT_VALUE, rd);
    check_data("exit readback", 32'hCAFE_0051, rd);
    reg_write("exit second", EXIT_BASE + REG_EXIT_VALUE, 32'h0000_1234);
    check_bit("exit second valid", 1'b1, exit_valid);
    check_data("exit second value", 32'hCAFE_0051, exit_value);
  endtask

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    rst_n   = 1'b0;
    reg_req = '0;
    obi_req = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    switch_transition("switch latency", 4'b0101, 1'b0);
    test_done_interrupt();
    test_decode_error();
    test_memory();
    test_exit_register();
    $display("Summary: %0d check errors, %0d assertion failures",
             errors, uut.assertions_i.fail_count);
    if (errors == 0 && uut.assertions_i.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/ext_harness_assertions.sv
// Bound checks on switch acknowledge latency, interrupt masking
// and OBI response order
module ext_harness_assertions
  import harness_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic [NUM_DOMAINS-1:0] switch_n_i,
  input logic [NUM_DOMAINS-1:0] ack_n_i,
  input logic                   intr_i,
  input reg_req_t               reg_req_i,
  input obi_rsp_t               obi_rsp_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;
  int unsigned settle_q;
  logic        irq_en_seen_q;

  // Delay line history is valid once it has filled after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      settle_q <= 0;
    end else if (settle_q < SWITCH_ACK_LATENCY) begin
      settle_q <= settle_q + 1;
    end
  end

  // Interrupt enable as last written on the register bus
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_en_seen_q <= 1'b0;
    end else if (reg_req_i.valid && reg_req_i.write &&
                 reg_req_i.addr == POWER_BASE + REG_IRQ_EN) begin
      irq_en_seen_q <= reg_req_i.wdata[0];
    end
  end

  ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (settle_q >= SWITCH_ACK_LATENCY) |-> (ack_n_i == $past(switch_n_i, SWITCH_ACK_LATENCY)))
  else begin
    fail_count++;
    $error("ack_n differs from switch_n delayed by the switch latency");
  end

  intr_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    intr_i |-> irq_en_seen_q)
  else begin
    fail_count++;
    $error("interrupt raised while its enable is clear");
  end

  // Upstream grant leads rvalid by two cycles
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_rsp_i.rvalid |-> $past(obi_rsp_i.gnt, 2))
  else begin
    fail_count++;
    $error("OBI rvalid without a grant two cycles earlier");
  end

endmodule

bind ext_harness_top ext_harness_assertions #(
  .NUM_DOMAINS       (NUM_DOMAINS),
  .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
) assertions_i (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .switch_n_i(switch_n_o),
  .ack_n_i   (ack_n_o),
  .intr_i    (intr_o),
  .reg_req_i (reg_req_i),
  .obi_rsp_i (obi_rsp_o)
);

//--- rtl/ext_harness_top.sv
// External harness top: register decode, power control, switch model,
// exit register, OBI buffer and slow memory
module ext_harness_top
  import harness_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15,
  parameter int unsigned MEM_WORDS          = 1024
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  reg_req_t               reg_req_i,
  output reg_rsp_t               reg_rsp_o,
  input  obi_req_t               obi_req_i,
  output obi_rsp_t               obi_rsp_o,
  output logic [NUM_DOMAINS-1:0] switch_n_o,
  output logic [NUM_DOMAINS-1:0] ack_n_o,
  output logic                   intr_o,
  output logic                   exit_valid_o,
  output data_t                  exit_value_o
);

  reg_req_t power_req;
  reg_rsp_t power_rsp;
  reg_req_t exit_req;
  reg_rsp_t exit_rsp;
  obi_req_t mem_req;
  obi_rsp_t mem_rsp;

  periph_decode periph_decode_i (
    .req_i      (reg_req_i),
    .rsp_o      (reg_rsp_o),
    .power_req_o(power_req),
    .power_rsp_i(power_rsp),
    .exit_req_o (exit_req),
    .exit_rsp_i (exit_rsp)
  );

  power_ctrl_regs #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) power_ctrl_regs_i (
    .clk_i,
    .rst_n_i,
    .req_i     (power_req),
    .rsp_o     (power_rsp),
    .ack_n_i   (ack_n_o),
    .switch_n_o(switch_n_o),
    .intr_o    (intr_o)
  );

  switch_ack_model #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) switch_ack_model_i (
    .clk_i,
    .rst_n_i,
    .switch_n_i(switch_n_o),
    .ack_n_o   (ack_n_o)
  );

  exit_regs exit_regs_i (
    .clk_i,
    .rst_n_i,
    .req_i       (exit_req),
    .rsp_o       (exit_rsp),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  obi_buffer obi_buffer_i (
    .clk_i,
    .rst_n_i,
    .up_req_i  (obi_req_i),
    .up_rsp_o  (obi_rsp_o),
    .down_req_o(mem_req),
    .down_rsp_i(mem_rsp)
  );

  slow_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) slow_memory_i (
    .clk_i,
    .rst_n_i,
    .req_i(mem_req),
    .rsp_o(mem_rsp)
  );

endmodule

//--- rtl/slow_memory.sv
// Word memory with byte enables and a one-cycle read response
module slow_memory
  import harness_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  obi_req_t req_i,
  output obi_rsp_t rsp_o
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  data_t             mem_q [MEM_WORDS];
  logic  [IDX_W-1:0] idx;
  logic              rvalid_q;
  data_t             rdata_q;

  assign idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : mem_q[idx];
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

//--- rtl/obi_buffer.sv
// One-entry OBI request buffer in front of the slow memory
module obi_buffer
  import harness_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  obi_req_t up_req_i,
  output obi_rsp_t up_rsp_o,
  output obi_req_t down_req_o,
  input  obi_rsp_t down_rsp_i
);

  typedef enum logic [1:0] {
    BUF_IDLE,
    BUF_ISSUE,
    BUF_WAIT
  } buf_state_e;

  buf_state_e state_q;
  obi_req_t   buf_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= BUF_IDLE;
    end else begin
      case (state_q)
        BUF_IDLE:  if (up_req_i.req) state_q <= BUF_ISSUE;
        BUF_ISSUE: if (down_rsp_i.gnt) state_q <= BUF_WAIT;
        BUF_WAIT:  if (down_rsp_i.rvalid) state_q <= BUF_IDLE;
        default:   state_q <= BUF_IDLE;
      endcase
    end
  end

  // Captured on the upstream grant
  always_ff @(posedge clk_i) begin
    if (state_q == BUF_IDLE && up_req_i.req) begin
      buf_q <= up_req_i;
    end
  end

  always_comb begin
    down_req_o     = buf_q;
    down_req_o.req = (state_q == BUF_ISSUE);
  end

  // Response passes straight through
  assign up_rsp_o.gnt    = (state_q == BUF_IDLE) && up_req_i.req;
  assign up_rsp_o.rvalid = (state_q == BUF_WAIT) && down_rsp_i.rvalid;
  assign up_rsp_o.rdata  = down_rsp_i.rdata;

endmodule

//--- rtl/exit_regs.sv
// Simulation exit register, written once after reset
module exit_regs
  import harness_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o,
  output data_t    exit_value_o,
  output logic     exit_valid_o
);

  data_t value_q;
  logic  valid_q;
  addr_t offset;

  assign offset = req_i.addr & (SLOT_SPAN - 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      value_q <= '0;
      valid_q <= 1'b0;
    end else if (req_i.valid && req_i.write && offset == REG_EXIT_VALUE && !valid_q) begin
      // Later writes are dropped until reset
      value_q <= req_i.wdata;
      valid_q <= 1'b1;
    end
  end

  always_comb begin
    rsp_o.rdata = (offset == REG_EXIT_VALUE) ? value_q : '0;
    rsp_o.error = 1'b0;
    rsp_o.ready = req_i.valid;
  end

  assign exit_value_o = value_q;
  assign exit_valid_o = valid_q;

endmodule

//--- rtl/switch_ack_model.sv
// Switch cell model delaying each switch request to its acknowledge
module switch_ack_model #(
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] ack_n_o
);

  logic [NUM_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Last stage is the acknowledge
  assign ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

//--- rtl/power_ctrl_regs.sv
// Power switch register, acknowledge status and done interrupt
module power_ctrl_regs
  import harness_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  reg_req_t               req_i,
  output reg_rsp_t               rsp_o,
  input  logic [NUM_DOMAINS-1:0] ack_n_i,
  output logic [NUM_DOMAINS-1:0] switch_n_o,
  output logic                   intr_o
);

  logic [NUM_DOMAINS-1:0] switch_q;
  logic                   pending_q;
  logic                   done_q;
  logic                   irq_en_q;
  addr_t                  offset;
  logic                   wr_en;
  logic                   ack_match;

  assign offset    = req_i.addr & (SLOT_SPAN - 1);
  assign wr_en     = req_i.valid && req_i.write;
  assign ack_match = pending_q && (ack_n_i == switch_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      switch_q  <= '0;
      pending_q <= 1'b0;
    end else begin
      if (ack_match) begin
        pending_q <= 1'b0;
      end
      // A new switch pattern starts a transition
      if (wr_en && offset == REG_SWITCH) begin
        switch_q <= req_i.wdata[NUM_DOMAINS-1:0];
        if (req_i.wdata[NUM_DOMAINS-1:0] != switch_q) begin
          pending_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q   <= 1'b0;
      irq_en_q <= 1'b0;
    end else begin
      // Write 1 to clear, a new completion wins
      if (wr_en && offset == REG_IRQ && req_i.wdata[0]) begin
        done_q <= 1'b0;
      end
      if (ack_match) begin
        done_q <= 1'b1;
      end
      if (wr_en && offset == REG_IRQ_EN) begin
        irq_en_q <= req_i.wdata[0];
      end
    end
  end

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b0;
    rsp_o.ready = req_i.valid;
    case (offset)
      REG_SWITCH:     rsp_o.rdata[NUM_DOMAINS-1:0] = switch_q;
      REG_ACK_STATUS: rsp_o.rdata[NUM_DOMAINS-1:0] = ack_n_i;
      REG_IRQ:        rsp_o.rdata[0] = done_q;
      REG_IRQ_EN:     rsp_o.rdata[0] = irq_en_q;
      default:        rsp_o.rdata = '0;
    endcase
  end

  assign switch_n_o = switch_q;
  assign intr_o     = done_q & irq_en_q;

endmodule

//--- rtl/periph_decode.sv
// Register bus decoder for the power and exit slots
// Unmapped addresses get an error response
module periph_decode
  import harness_pkg::*;
(
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o,
  output reg_req_t power_req_o,
  input  reg_rsp_t power_rsp_i,
  output reg_req_t exit_req_o,
  input  reg_rsp_t exit_rsp_i
);

  slot_e sel;
  logic  hit;

  always_comb begin
    hit = 1'b1;
    sel = SLOT_POWER;
    if (req_i.addr >= POWER_BASE && req_i.addr < POWER_BASE + SLOT_SPAN) begin
      sel = SLOT_POWER;
    end else if (req_i.addr >= EXIT_BASE && req_i.addr < EXIT_BASE + SLOT_SPAN) begin
      sel = SLOT_EXIT;
    end else begin
      hit = 1'b0;
    end
  end

  // Only the selected slot sees valid
  always_comb begin
    power_req_o       = req_i;
    exit_req_o        = req_i;
    power_req_o.valid = req_i.valid && hit && (sel == SLOT_POWER);
    exit_req_o.valid  = req_i.valid && hit && (sel == SLOT_EXIT);
  end

  always_comb begin
    if (!hit) begin
      rsp_o.rdata = '0;
      rsp_o.error = 1'b1;
      rsp_o.ready = req_i.valid;
    end else if (sel == SLOT_EXIT) begin
      rsp_o = exit_rsp_i;
    end else begin
      rsp_o = power_rsp_i;
    end
  end

endmodule

//--- rtl/harness_pkg.sv
// Bus widths, register bus and OBI structs
// Register slot map and register offsets
package harness_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Register bus, answered in the same cycle as valid
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t wstrb;
    logic  valid;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
    logic  ready;
  } reg_rsp_t;

  // OBI request and response
  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_rsp_t;

  typedef enum logic {
    SLOT_POWER,
    SLOT_EXIT
  } slot_e;

  // Register slots, 256 bytes each
  localparam addr_t POWER_BASE = 32'h2000_0000;
  localparam addr_t EXIT_BASE  = 32'h2000_0100;
  localparam addr_t SLOT_SPAN  = 32'h0000_0100;

  // Power control offsets
  localparam addr_t REG_SWITCH     = 32'h0;
  localparam addr_t REG_ACK_STATUS = 32'h4;
  localparam addr_t REG_IRQ        = 32'h8;
  localparam addr_t REG_IRQ_EN     = 32'hC;

  // Exit slot offset
  localparam addr_t REG_EXIT_VALUE = 32'h0;

endpackage
